//--- logic/lsu_config.svh
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// ---------------------------------------------------------------------------
// widths and memory geometry
// ---------------------------------------------------------------------------
`define LSU_XLEN     32
`define DMEM_WORDS   512
`define DMEM_IDX_W   9
`define DMEM_SPAN_W  11   // 2 KB of byte address

// ---------------------------------------------------------------------------
// I/O map
// ---------------------------------------------------------------------------
`define IO_PAGE      4'h1     // addr[31:28]
`define IO_LEDR      4'h0     // addr[15:12] within the I/O page
`define IO_LEDG      4'h1
`define IO_HEX_LO    4'h2
`define IO_HEX_HI    4'h3
`define IO_LCD       4'h4
`define IO_SW_SEL    16'h0010 // addr[27:12], base 0x1001_0000

`define HEX_DIGIT_W  7

`endif

//--- logic/lsu_pkg.sv
`default_nettype none

`include "lsu_config.svh"

package lsu_pkg;

	// funct3 encoding of the access size
	typedef enum logic [2:0] {
		SZ_B  = 3'd0,
		SZ_H  = 3'd1,
		SZ_W  = 3'd2,
		SZ_BU = 3'd4,
		SZ_HU = 3'd5
	} lsu_size_e;

	typedef struct packed {
		logic [`LSU_XLEN-1:0] addr;
		logic [`LSU_XLEN-1:0] wdata;
		logic                 wren;
		lsu_size_e            size;
	} lsu_req_t;

	typedef enum logic [2:0] {
		REG_MEM,
		REG_LEDR,
		REG_LEDG,
		REG_HEX_LO,
		REG_HEX_HI,
		REG_LCD,
		REG_SW,
		REG_NONE
	} lsu_region_e;

	typedef struct packed {
		logic                    pad;
		logic [`HEX_DIGIT_W-1:0] seg;
	} hex_digit_t;

	// one bus word seen either flat or as four digit bytes
	typedef union packed {
		logic [`LSU_XLEN-1:0] raw;
		struct packed {
			hex_digit_t d3;
			hex_digit_t d2;
			hex_digit_t d1;
			hex_digit_t d0; // low byte
		} digits;
	} hex_word_u;

endpackage

`default_nettype wire

//--- logic/lsu_addr_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_config.svh"

module lsu_addr_decode
	import lsu_pkg::*;
(
	input  lsu_req_t    i_req,
	output lsu_region_e o_region
);

	logic [3:0]  page;
	logic [11:0] io_mid;
	logic [3:0]  io_sel;
	logic [15:0] sw_sel;

	assign page   = i_req.addr[31:28];
	assign io_mid = i_req.addr[27:16];
	assign io_sel = i_req.addr[15:12];
	assign sw_sel = i_req.addr[27:12];

	always_comb begin
		o_region = REG_NONE;
		if (i_req.addr[`LSU_XLEN-1:`DMEM_SPAN_W] == '0) begin
			o_region = REG_MEM;
		end else if (page == `IO_PAGE && io_mid == '0) begin
			case (io_sel)
				`IO_LEDR:   o_region = REG_LEDR;
				`IO_LEDG:   o_region = REG_LEDG;
				`IO_HEX_LO: o_region = REG_HEX_LO;
				`IO_HEX_HI: o_region = REG_HEX_HI;
				`IO_LCD:    o_region = REG_LCD;
				default:    o_region = REG_NONE; // rest of the page is a hole
			endcase
		end else if (page == `IO_PAGE && sw_sel == `IO_SW_SEL) begin
			o_region = REG_SW;
		end
	end

endmodule

`default_nettype wire

//--- logic/dmem_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_config.svh"

module dmem_ram (
	input  logic                   clock,
	input  logic                   i_we_a,
	input  logic [`DMEM_IDX_W-1:0] i_idx_a,
	input  logic [`LSU_XLEN-1:0]   i_wdata_a,
	input  logic                   i_we_b,
	input  logic [`DMEM_IDX_W-1:0] i_idx_b,
	input  logic [`LSU_XLEN-1:0]   i_wdata_b,
	output logic [`LSU_XLEN-1:0]   o_rdata_a,
	output logic [`LSU_XLEN-1:0]   o_rdata_b
);

	logic [`LSU_XLEN-1:0] mem [0:`DMEM_WORDS-1];

	always_ff @(posedge clock) begin
		if (i_we_a)
			mem[i_idx_a] <= i_wdata_a;
		if (i_we_b)
			mem[i_idx_b] <= i_wdata_b;
	end

	assign o_rdata_a = mem[i_idx_a]; // async read
	assign o_rdata_b = mem[i_idx_b];

	// the two window words are always distinct rows
	assert property (@(posedge clock) !(i_we_a && i_we_b && i_idx_a == i_idx_b))
		else $error("both RAM ports wrote index %0d", i_idx_a);

endmodule

`default_nettype wire

//--- logic/lsu_dmem.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_config.svh"

module lsu_dmem
	import lsu_pkg::*;
(
	input  logic                 clock,
	input  lsu_req_t             i_req,
	input  lsu_region_e          i_region,
	output logic [`LSU_XLEN-1:0] o_rdata
);

	logic [`DMEM_IDX_W-1:0]  idx_lo;
	logic [`DMEM_IDX_W-1:0]  idx_hi;
	logic [1:0]              byte_off;
	logic [4:0]              bit_off;
	logic [`LSU_XLEN-1:0]    word_lo;
	logic [`LSU_XLEN-1:0]    word_hi;
	logic [2*`LSU_XLEN-1:0]  window;
	logic [2*`LSU_XLEN-1:0]  merged;
	logic [`LSU_XLEN-1:0]    shifted;
	logic                    we;

	assign idx_lo   = i_req.addr[`DMEM_SPAN_W-1:2];
	assign idx_hi   = idx_lo + 1'b1; // wraps at the last word
	assign byte_off = i_req.addr[1:0];
	assign bit_off  = {byte_off, 3'b000};
	assign window   = {word_hi, word_lo};
	assign we       = i_req.wren && (i_region == REG_MEM);

	dmem_ram dmem_ram_i (
		.clock     (clock),
		.i_we_a    (we),
		.i_idx_a   (idx_lo),
		.i_wdata_a (merged[`LSU_XLEN-1:0]),
		.i_we_b    (we),
		.i_idx_b   (idx_hi),
		.i_wdata_b (merged[2*`LSU_XLEN-1:`LSU_XLEN]),
		.o_rdata_a (word_lo),
		.o_rdata_b (word_hi)
	);

	// ---------------------------------------------------------------------------
	// store merge into the two-word window
	// ---------------------------------------------------------------------------
	always_comb begin
		merged = window;
		case (i_req.size)
			SZ_W:    merged[bit_off +: 32] = i_req.wdata;
			SZ_H:    merged[bit_off +: 16] = i_req.wdata[15:0];
			SZ_B:    merged[bit_off +: 8]  = i_req.wdata[7:0];
			default: merged = window; // write back what is there
		endcase
	end

	// ---------------------------------------------------------------------------
	// load extract
	// ---------------------------------------------------------------------------
	assign shifted = window[bit_off +: 32];

	always_comb begin
		case (i_req.size)
			SZ_W:    o_rdata = shifted;
			SZ_H:    o_rdata = {{16{shifted[15]}}, shifted[15:0]};
			SZ_B:    o_rdata = {{24{shifted[7]}}, shifted[7:0]};
			SZ_HU:   o_rdata = {16'b0, shifted[15:0]};
			SZ_BU:   o_rdata = {24'b0, shifted[7:0]};
			default: o_rdata = word_lo;
		endcase
	end

endmodule

`default_nettype wire

//--- logic/lsu_io_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_config.svh"

module lsu_io_regs
	import lsu_pkg::*;
(
	input  logic                                clock,
	input  logic                                i_reset,
	input  lsu_req_t                            i_req,
	input  lsu_region_e                         i_region,
	input  logic [`LSU_XLEN-1:0]                i_io_sw,
	output logic [`LSU_XLEN-1:0]                o_rdata,
	output logic [`LSU_XLEN-1:0]                o_io_ledr,
	output logic [`LSU_XLEN-1:0]                o_io_ledg,
	output logic [`LSU_XLEN-1:0]                o_io_lcd,
	output logic [7:0][`HEX_DIGIT_W-1:0]        o_io_hex
);

	logic [`LSU_XLEN-1:0]         ledr_q;
	logic [`LSU_XLEN-1:0]         ledg_q;
	logic [`LSU_XLEN-1:0]         lcd_q;
	logic [`LSU_XLEN-1:0]         sw_q;
	logic [7:0][`HEX_DIGIT_W-1:0] hex_q;
	hex_word_u                    st_word;
	hex_word_u                    rb_lo;
	hex_word_u                    rb_hi;

	// four digits back into a bus word, pads cleared
	function automatic hex_word_u pack_digits(input logic [3:0][`HEX_DIGIT_W-1:0] segs);
		hex_word_u w;
		w.raw = '0;
		w.digits.d0.seg = segs[0];
		w.digits.d1.seg = segs[1];
		w.digits.d2.seg = segs[2];
		w.digits.d3.seg = segs[3];
		return w;
	endfunction

	assign st_word.raw = i_req.wdata;

	always_ff @(posedge clock) begin
		if (!i_reset) begin
			ledr_q <= '0;
			ledg_q <= '0;
			lcd_q  <= '0;
			sw_q   <= '0;
			hex_q  <= '0;
		end else begin
			sw_q <= i_io_sw; // sampled every cycle
			if (i_req.wren) begin
				case (i_region)
					REG_LEDR: ledr_q <= i_req.wdata;
					REG_LEDG: ledg_q <= i_req.wdata;
					REG_LCD:  lcd_q  <= i_req.wdata;
					REG_HEX_LO: begin
						hex_q[0] <= st_word.digits.d0.seg;
						hex_q[1] <= st_word.digits.d1.seg;
						hex_q[2] <= st_word.digits.d2.seg;
						hex_q[3] <= st_word.digits.d3.seg;
					end
					REG_HEX_HI: begin
						hex_q[4] <= st_word.digits.d0.seg;
						hex_q[5] <= st_word.digits.d1.seg;
						hex_q[6] <= st_word.digits.d2.seg;
						hex_q[7] <= st_word.digits.d3.seg;
					end
					default: ; // SW, NONE and MEM ignored here
				endcase
			end
		end
	end

	assign rb_lo = pack_digits(hex_q[3:0]);
	assign rb_hi = pack_digits(hex_q[7:4]);

	always_comb begin
		case (i_region)
			REG_LEDR:   o_rdata = ledr_q;
			REG_LEDG:   o_rdata = ledg_q;
			REG_LCD:    o_rdata = lcd_q;
			REG_HEX_LO: o_rdata = rb_lo.raw;
			REG_HEX_HI: o_rdata = rb_hi.raw;
			REG_SW:     o_rdata = sw_q;
			default:    o_rdata = '0;
		endcase
	end

	assign o_io_ledr = ledr_q;
	assign o_io_ledg = ledg_q;
	assign o_io_lcd  = lcd_q;
	assign o_io_hex  = hex_q;

endmodule

`default_nettype wire

//--- logic/lsu_read_mux.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_config.svh"

module lsu_read_mux
	import lsu_pkg::*;
(
	input  logic                 i_reset,
	input  lsu_region_e          i_region,
	input  logic [`LSU_XLEN-1:0] i_mem_rdata,
	input  logic [`LSU_XLEN-1:0] i_io_rdata,
	output logic [`LSU_XLEN-1:0] o_ld_data
);

	always_comb begin
		if (!i_reset) begin
			o_ld_data = '0; // quiet bus while in reset
		end else begin
			case (i_region)
				REG_MEM:  o_ld_data = i_mem_rdata;
				REG_NONE: o_ld_data = '0;
				default:  o_ld_data = i_io_rdata; // I/O and switch
			endcase
		end
	end

endmodule

`default_nettype wire

//--- logic/lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_config.svh"

module lsu_top
	import lsu_pkg::*;
(
	input  logic                         clock,
	input  logic                         i_reset,
	input  lsu_req_t                     i_req,
	input  logic [`LSU_XLEN-1:0]         i_io_sw,
	output logic [`LSU_XLEN-1:0]         o_ld_data,
	output logic [`LSU_XLEN-1:0]         o_io_ledr,
	output logic [`LSU_XLEN-1:0]         o_io_ledg,
	output logic [`LSU_XLEN-1:0]         o_io_lcd,
	output logic [7:0][`HEX_DIGIT_W-1:0] o_io_hex
);

	lsu_region_e          region;
	logic [`LSU_XLEN-1:0] mem_rdata;
	logic [`LSU_XLEN-1:0] io_rdata;

	lsu_addr_decode lsu_addr_decode_i (
		.i_req    (i_req),
		.o_region (region)
	);

	lsu_dmem lsu_dmem_i (
		.clock    (clock),
		.i_req    (i_req),
		.i_region (region),
		.o_rdata  (mem_rdata)
	);

	lsu_io_regs lsu_io_regs_i (
		.clock     (clock),
		.i_reset   (i_reset),
		.i_req     (i_req),
		.i_region  (region),
		.i_io_sw   (i_io_sw),
		.o_rdata   (io_rdata),
		.o_io_ledr (o_io_ledr),
		.o_io_ledg (o_io_ledg),
		.o_io_lcd  (o_io_lcd),
		.o_io_hex  (o_io_hex)
	);

	lsu_read_mux lsu_read_mux_i (
		.i_reset     (i_reset),
		.i_region    (region),
		.i_mem_rdata (mem_rdata),
		.i_io_rdata  (io_rdata),
		.o_ld_data   (o_ld_data)
	);

endmodule

`default_nettype wire

//--- tests/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
	parameter int HALF_NS = 20 // 40 ns period
) (
	output logic o_clock
);

	initial begin
		o_clock = 1'b0;
		forever #(HALF_NS) o_clock = ~o_clock;
	end

endmodule

`default_nettype wire

//--- tests/lsu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_tb
	import lsu_pkg::*;
();

	typedef struct packed {
		lsu_req_t        req;
		logic [31:0]     sw;
		logic [31:0]     exp_ld;
		logic [31:0]     exp_ledr;
		logic [31:0]     exp_ledg;
		logic [31:0]     exp_lcd;
		logic [7:0][6:0] exp_hex;
	} row_t;

	logic            clock;
	logic            i_reset;
	lsu_req_t        i_req;
	logic [31:0]     i_io_sw;
	logic [31:0]     o_ld_data;
	logic [31:0]     o_io_ledr;
	logic [31:0]     o_io_ledg;
	logic [31:0]     o_io_lcd;
	logic [7:0][6:0] o_io_hex;

	logic [7:0]      mem_m [0:2047]; // byte view of data memory
	logic [31:0]     ledr_m;
	logic [31:0]     ledg_m;
	logic [31:0]     lcd_m;
	logic [31:0]     sw_m;
	logic [7:0][6:0] hex_m;
	row_t            table_q[$];
	row_t            zero_row;

	tb_clock tb_clock_i (
		.o_clock (clock)
	);

	lsu_top lsu_top_i (
		.clock     (clock),
		.i_reset   (i_reset),
		.i_req     (i_req),
		.i_io_sw   (i_io_sw),
		.o_ld_data (o_ld_data),
		.o_io_ledr (o_io_ledr),
		.o_io_ledg (o_io_ledg),
		.o_io_lcd  (o_io_lcd),
		.o_io_hex  (o_io_hex)
	);

	// ------------------------------------------------------------------------
	// reference model
	// ------------------------------------------------------------------------
	function automatic lsu_region_e model_region(input logic [31:0] a);
		if (a[31:11] == 21'd0)
			return REG_MEM;
		if (a[31:28] == 4'h1 && a[27:16] == 12'd0) begin
			case (a[15:12])
				4'h0:    return REG_LEDR;
				4'h1:    return REG_LEDG;
				4'h2:    return REG_HEX_LO;
				4'h3:    return REG_HEX_HI;
				4'h4:    return REG_LCD;
				default: return REG_NONE;
			endcase
		end
		if (a[31:28] == 4'h1 && a[27:12] == 16'd16)
			return REG_SW;
		return REG_NONE;
	endfunction

	function automatic int size_bytes(input lsu_size_e sz);
		case (sz)
			SZ_W:        return 4;
			SZ_H, SZ_HU: return 2;
			default:     return 1;
		endcase
	endfunction

	// little endian bytes, wrapping at 2 KB
	function automatic logic [31:0] model_mem_load(input logic [31:0] a, input lsu_size_e sz);
		logic [31:0] v;
		logic [10:0] b;
		v = '0;
		b = a[10:0];
		for (int k = 0; k < size_bytes(sz); k++)
			v[8*k +: 8] = mem_m[b + 11'(k)];
		if (sz == SZ_B && v[7])
			v[31:8] = '1;
		if (sz == SZ_H && v[15])
			v[31:16] = '1;
		return v;
	endfunction

	task automatic add_row(input logic [31:0] a, input lsu_size_e sz, input logic wr,
		input logic [31:0] wd);
		row_t        r;
		lsu_region_e rg;
		logic [10:0] b;
		rg = model_region(a);
		b = a[10:0];
		r = '0;
		r.req.addr = a;
		r.req.wdata = wd;
		r.req.wren = wr;
		r.req.size = sz;
		r.sw = $urandom;
		case (rg)
			REG_MEM:    r.exp_ld = model_mem_load(a, sz);
			REG_LEDR:   r.exp_ld = ledr_m;
			REG_LEDG:   r.exp_ld = ledg_m;
			REG_LCD:    r.exp_ld = lcd_m;
			REG_SW:     r.exp_ld = sw_m; // value from the previous row
			REG_HEX_LO: for (int k = 0; k < 4; k++) r.exp_ld[8*k +: 8] = {1'b0, hex_m[k]};
			REG_HEX_HI: for (int k = 0; k < 4; k++) r.exp_ld[8*k +: 8] = {1'b0, hex_m[4+k]};
			default:    r.exp_ld = '0;
		endcase
		if (wr) begin
			case (rg)
				REG_MEM: begin
					if (sz inside {SZ_B, SZ_H, SZ_W}) begin
						for (int k = 0; k < size_bytes(sz); k++)
							mem_m[b + 11'(k)] = wd[8*k +: 8];
					end
				end
				REG_LEDR:   ledr_m = wd;
				REG_LEDG:   ledg_m = wd;
				REG_LCD:    lcd_m = wd;
				REG_HEX_LO: for (int k = 0; k < 4; k++) hex_m[k] = wd[8*k +: 7];
				REG_HEX_HI: for (int k = 0; k < 4; k++) hex_m[4+k] = wd[8*k +: 7];
				default: ;
			endcase
		end
		sw_m = r.sw;
		r.exp_ledr = ledr_m;
		r.exp_ledg = ledg_m;
		r.exp_lcd = lcd_m;
		r.exp_hex = hex_m;
		table_q.push_back(r);
	endtask

	task automatic store_row(input logic [31:0] a, input lsu_size_e sz, input logic [31:0] d);
		add_row(a, sz, 1'b1, d);
	endtask

	task automatic load_row(input logic [31:0] a, input lsu_size_e sz);
		add_row(a, sz, 1'b0, $urandom);
	endtask

	task automatic build_table();
		logic [31:0] init_addrs [10] = '{32'h000, 32'h010, 32'h014, 32'h018, 32'h100,
			32'h104, 32'h108, 32'h10c, 32'h7f8, 32'h7fc};
		logic [31:0] d;
		ledr_m = '0;
		ledg_m = '0;
		lcd_m = '0;
		sw_m = '0;
		hex_m = '0;
		foreach (init_addrs[n]) store_row(init_addrs[n], SZ_W, $urandom);
		foreach (init_addrs[n]) load_row(init_addrs[n], SZ_W);
		for (int off = 0; off < 4; off++) begin
			d = $urandom;
			d[7] = off[0]; // both signs
			store_row(32'h100 + off, SZ_B, d);
			load_row(32'h100 + off, SZ_B);
			load_row(32'h100 + off, SZ_BU);
			load_row(32'h100, SZ_W);
		end
		for (int off = 0; off < 4; off++) begin
			d = $urandom;
			d[15] = off[0];
			store_row(32'h104 + off, SZ_H, d);
			load_row(32'h104 + off, SZ_H);
			load_row(32'h104 + off, SZ_HU);
			load_row(32'h104, SZ_W);
			load_row(32'h108, SZ_W);
		end
		for (int off = 1; off < 4; off++) begin
			d = $urandom;
			d[31] = off[0];
			store_row(32'h010 + off, SZ_W, d);
			load_row(32'h010 + off, SZ_W);
			load_row(32'h010, SZ_W);
			load_row(32'h014, SZ_W);
		end
		load_row(32'h017, SZ_H);
		store_row(32'h7fd, SZ_W, $urandom); // wraps into word 0
		load_row(32'h7fd, SZ_W);
		load_row(32'h7fc, SZ_W);
		load_row(32'h000, SZ_W);
		for (int n = 0; n < 5; n++) begin
			store_row(32'h1000_0000 + (n << 12), SZ_W, $urandom);
			load_row(32'h1000_0000 + (n << 12), SZ_W);
		end
		load_row(32'h1001_0000, SZ_W);
		load_row(32'h1001_0000, SZ_W);
		store_row(32'h1000_5000, SZ_W, $urandom);
		load_row(32'h1000_5000, SZ_W);
		store_row(32'h2000_0000, SZ_W, $urandom);
		load_row(32'h2000_0000, SZ_W);
		store_row(32'h0000_0800, SZ_W, $urandom); // just past memory
		load_row(32'h0000_0800, SZ_W);
		load_row(32'h000, SZ_W);
	endtask

	// ------------------------------------------------------------------------
	// checks and waits
	// ------------------------------------------------------------------------
	task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("FAILED at %0t: %s got %h expected %h", $time, what, actual, expected);
			$display("*** TEST FAILED ***");
			$fatal(1, "mismatch");
		end
	endtask

	task automatic check_snapshot(input row_t r, input string tag);
		check_value(o_io_ledr, r.exp_ledr, $sformatf("%s ledr", tag));
		check_value(o_io_ledg, r.exp_ledg, $sformatf("%s ledg", tag));
		check_value(o_io_lcd, r.exp_lcd, $sformatf("%s lcd", tag));
		check_value(o_io_hex, r.exp_hex, $sformatf("%s hex", tag));
	endtask

	task automatic wait_fall();
		int steps;
		bit seen_high;
		steps = 0;
		seen_high = 1'b0;
		while (!(seen_high && clock === 1'b0)) begin
			if (clock === 1'b1)
				seen_high = 1'b1;
			if (steps == 100) begin
				$display("timeout: the clock stopped toggling at %0t", $time);
				$display("*** TEST FAILED ***");
				$fatal(1, "clock timeout");
			end
			#1;
			steps++;
		end
	endtask

	initial begin
		void'($urandom(32'h22db_9cc5));
		zero_row = '0;
		i_reset = 1'b0;
		i_req = '0;
		i_req.addr = $urandom & 32'h0000_07fc; // a memory load while in reset
		i_req.size = SZ_W;
		i_io_sw = $urandom;
		build_table();

		for (int c = 0; c < 8; c++) begin
			wait_fall();
			check_value(o_ld_data, '0, "load data during reset");
		end
		check_snapshot(zero_row, "after reset");
		i_reset = 1'b1;

		for (int i = 0; i < table_q.size(); i++) begin
			if (i > 0)
				check_snapshot(table_q[i-1], $sformatf("row %0d", i - 1));
			i_req = table_q[i].req;
			i_io_sw = table_q[i].sw;
			#10;
			if (!table_q[i].req.wren)
				check_value(o_ld_data, table_q[i].exp_ld, $sformatf("row %0d load", i));
			wait_fall();
		end
		check_snapshot(table_q[table_q.size()-1], "last row");

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- sources.f
+incdir+logic
logic/lsu_pkg.sv
logic/lsu_addr_decode.sv
logic/dmem_ram.sv
logic/lsu_dmem.sv
logic/lsu_io_regs.sv
logic/lsu_read_mux.sv
logic/lsu_top.sv
tests/tb_clock.sv
tests/lsu_tb.sv

//--- run.sh
#!/bin/sh
# build and run the LSU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f sources.f \
	--top-module lsu_tb \
	-o lsu_sim

./obj_dir/lsu_sim
